// ==== src/issue_defs.svh ====
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

`define ISU_WORD_W 32
`define ISU_ID_W   7
`define ISU_REG_W  7
`define ISU_UNIT_W 3
`define ISU_LAT_W  4
`define ISU_IMM_W  18 // one immediate per slot, zero-extended

// leading opcode bits, sized to each format's op field
`define ISU_OP_A    11'h0c0
`define ISU_OP_AI   8'h1c
`define ISU_OP_IL   9'h081
`define ISU_OP_ILA  7'h21
`define ISU_OP_LQD  8'h34
`define ISU_OP_STQD 8'h24
`define ISU_OP_NOP  11'h201 // even pipe no-op
`define ISU_OP_LNOP 11'h001 // odd pipe no-op

`define ISU_ID_NOP  7'd0
`define ISU_ID_LNOP 7'd1
`define ISU_ID_A    7'd2
`define ISU_ID_AI   7'd3
`define ISU_ID_IL   7'd4
`define ISU_ID_ILA  7'd5
`define ISU_ID_LQD  7'd6
`define ISU_ID_STQD 7'd7

`define ISU_UNIT_NONE 3'd0
`define ISU_UNIT_FX   3'd1 // simple fixed point, even pipe
`define ISU_UNIT_LS   3'd5 // local store, odd pipe

`define ISU_LAT_FX 4'd2
`define ISU_LAT_LS 4'd6

`endif

// ==== src/isa_pkg.sv ====
`default_nettype none
`include "issue_defs.svh"

package isa_pkg;

  typedef struct packed {
    logic [0:10]            op;
    logic [0:`ISU_REG_W-1] rb;
    logic [0:`ISU_REG_W-1] ra;
    logic [0:`ISU_REG_W-1] rt;
  } rr_fmt_t;

  typedef struct packed {
    logic [0:7]             op;
    logic [0:9]             i10;
    logic [0:`ISU_REG_W-1] ra;
    logic [0:`ISU_REG_W-1] rt;
  } ri10_fmt_t;

  typedef struct packed {
    logic [0:8]             op;
    logic [0:15]            i16;
    logic [0:`ISU_REG_W-1] rt;
  } ri16_fmt_t;

  typedef struct packed {
    logic [0:6]             op;
    logic [0:17]            i18;
    logic [0:`ISU_REG_W-1] rt;
  } ri18_fmt_t;

  // same 32 bits, read through whichever format the opcode selects
  typedef union packed {
    rr_fmt_t   rr;
    ri10_fmt_t ri10;
    ri16_fmt_t ri16;
    ri18_fmt_t ri18;
  } instr_word_u;

endpackage

`default_nettype wire

// ==== src/pipe_pkg.sv ====
`default_nettype none
`include "issue_defs.svh"

package pipe_pkg;

  function automatic logic is_even_pipe(input logic [0:`ISU_ID_W-1] id);
    case (id)
      `ISU_ID_LNOP, `ISU_ID_LQD, `ISU_ID_STQD: return 1'b0;
      default: return 1'b1; // fixed point ops and nop
    endcase
  endfunction

  function automatic logic [0:`ISU_UNIT_W-1] unit_of(input logic [0:`ISU_ID_W-1] id);
    case (id)
      `ISU_ID_A, `ISU_ID_AI, `ISU_ID_IL, `ISU_ID_ILA: return `ISU_UNIT_FX;
      `ISU_ID_LQD, `ISU_ID_STQD: return `ISU_UNIT_LS;
      default: return `ISU_UNIT_NONE; // no-ops occupy no unit
    endcase
  endfunction

  function automatic logic [0:`ISU_LAT_W-1] latency_of(input logic [0:`ISU_ID_W-1] id);
    case (id)
      `ISU_ID_A, `ISU_ID_AI, `ISU_ID_IL, `ISU_ID_ILA: return `ISU_LAT_FX;
      `ISU_ID_LQD, `ISU_ID_STQD: return `ISU_LAT_LS;
      default: return '0;
    endcase
  endfunction

  // filler for an empty slot of the given pipe
  function automatic logic [0:`ISU_ID_W-1] filler_id(input logic even_pipe);
    if (even_pipe) begin
      return `ISU_ID_NOP;
    end
    return `ISU_ID_LNOP;
  endfunction

endpackage

`default_nettype wire

// ==== src/instr_decoder.sv ====
`default_nettype none
`include "issue_defs.svh"

module instr_decoder
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic [0:`ISU_WORD_W-1] word,
  output logic [0:`ISU_ID_W-1]   id,
  output logic [0:`ISU_REG_W-1]  reg_dst,
  output logic                   reg_wr,
  output logic [0:`ISU_UNIT_W-1] unit_id,
  output logic [0:`ISU_LAT_W-1]  latency,
  output logic [0:`ISU_IMM_W-1]  imm,
  output logic [0:`ISU_REG_W-1]  ra_addr,
  output logic [0:`ISU_REG_W-1]  rb_addr,
  output logic [0:`ISU_REG_W-1]  rc_addr,
  output logic                   ra_used,
  output logic                   rb_used,
  output logic                   rc_used
);

  instr_word_u w;

  assign w = word;

  // longest opcode first so shorter prefixes cannot alias
  always_comb begin
    id      = `ISU_ID_NOP; // anything unrecognised
    reg_dst = '0;
    reg_wr  = 1'b0;
    imm     = '0;
    ra_addr = '0;
    rb_addr = '0;
    rc_addr = '0;
    ra_used = 1'b0;
    rb_used = 1'b0;
    rc_used = 1'b0;
    if (w.rr.op == `ISU_OP_A) begin
      id      = `ISU_ID_A;
      reg_dst = w.rr.rt;
      reg_wr  = 1'b1;
      ra_addr = w.rr.ra;
      rb_addr = w.rr.rb;
      ra_used = 1'b1;
      rb_used = 1'b1;
    end else if (w.rr.op == `ISU_OP_NOP) begin
      id = `ISU_ID_NOP;
    end else if (w.rr.op == `ISU_OP_LNOP) begin
      id = `ISU_ID_LNOP;
    end else if (w.ri16.op == `ISU_OP_IL) begin
      id      = `ISU_ID_IL;
      reg_dst = w.ri16.rt;
      reg_wr  = 1'b1;
      imm     = {{(`ISU_IMM_W-16){1'b0}}, w.ri16.i16};
    end else if (w.ri10.op == `ISU_OP_AI) begin
      id      = `ISU_ID_AI;
      reg_dst = w.ri10.rt;
      reg_wr  = 1'b1;
      imm     = {{(`ISU_IMM_W-10){1'b0}}, w.ri10.i10};
      ra_addr = w.ri10.ra;
      ra_used = 1'b1;
    end else if (w.ri10.op == `ISU_OP_LQD) begin
      id      = `ISU_ID_LQD;
      reg_dst = w.ri10.rt;
      reg_wr  = 1'b1;
      imm     = {{(`ISU_IMM_W-10){1'b0}}, w.ri10.i10};
      ra_addr = w.ri10.ra; // base address register
      ra_used = 1'b1;
    end else if (w.ri10.op == `ISU_OP_STQD) begin
      id      = `ISU_ID_STQD;
      imm     = {{(`ISU_IMM_W-10){1'b0}}, w.ri10.i10};
      ra_addr = w.ri10.ra;
      ra_used = 1'b1;
      rc_addr = w.ri10.rt; // store data comes in on the rc port
      rc_used = 1'b1;
    end else if (w.ri18.op == `ISU_OP_ILA) begin
      id      = `ISU_ID_ILA;
      reg_dst = w.ri18.rt;
      reg_wr  = 1'b1;
      imm     = w.ri18.i18;
    end
  end

  assign unit_id = unit_of(id);
  assign latency = latency_of(id);

endmodule

`default_nettype wire

// ==== src/pair_hazard_check.sv ====
`default_nettype none
`include "issue_defs.svh"

module pair_hazard_check
  import pipe_pkg::*;
(
  input  logic [0:`ISU_ID_W-1]  id1,
  input  logic [0:`ISU_ID_W-1]  id2,
  input  logic [0:`ISU_REG_W-1] reg_dst1,
  input  logic                  reg_wr1,
  input  logic [0:`ISU_REG_W-1] ra_addr2,
  input  logic [0:`ISU_REG_W-1] rb_addr2,
  input  logic [0:`ISU_REG_W-1] rc_addr2,
  input  logic                  ra_used2,
  input  logic                  rb_used2,
  input  logic                  rc_used2,
  output logic                  instr1_even,
  output logic                  instr2_even,
  output logic                  split_needed
);

  logic pipe_clash;
  logic raw_dep;

  assign instr1_even = is_even_pipe(id1);
  assign instr2_even = is_even_pipe(id2);

  assign pipe_clash = (instr1_even == instr2_even); // only one slot per pipe

  // instr2 must see the result of instr1
  assign raw_dep = reg_wr1 &&
                   ((ra_used2 && (ra_addr2 == reg_dst1)) ||
                    (rb_used2 && (rb_addr2 == reg_dst1)) ||
                    (rc_used2 && (rc_addr2 == reg_dst1)));

  assign split_needed = pipe_clash || raw_dep;

endmodule

`default_nettype wire

// ==== src/dual_issue_ctrl.sv ====
`default_nettype none
`include "issue_defs.svh"

module dual_issue_ctrl
  import pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   find_nop,
  input  logic                   instr1_even,
  input  logic                   instr2_even,
  input  logic                   split_needed,
  input  logic [0:`ISU_ID_W-1]   id1,
  input  logic [0:`ISU_REG_W-1]  reg_dst1,
  input  logic                   reg_wr1,
  input  logic [0:`ISU_UNIT_W-1] unit_id1,
  input  logic [0:`ISU_LAT_W-1]  latency1,
  input  logic [0:`ISU_IMM_W-1]  imm1,
  input  logic [0:`ISU_REG_W-1]  ra_addr1,
  input  logic [0:`ISU_REG_W-1]  rb_addr1,
  input  logic [0:`ISU_REG_W-1]  rc_addr1,
  input  logic [0:`ISU_ID_W-1]   id2,
  input  logic [0:`ISU_REG_W-1]  reg_dst2,
  input  logic                   reg_wr2,
  input  logic [0:`ISU_UNIT_W-1] unit_id2,
  input  logic [0:`ISU_LAT_W-1]  latency2,
  input  logic [0:`ISU_IMM_W-1]  imm2,
  input  logic [0:`ISU_REG_W-1]  ra_addr2,
  input  logic [0:`ISU_REG_W-1]  rb_addr2,
  input  logic [0:`ISU_REG_W-1]  rc_addr2,
  output logic                   stall,
  output logic [0:`ISU_ID_W-1]   even_instr_id,
  output logic [0:`ISU_REG_W-1]  even_reg_dst,
  output logic                   even_reg_wr,
  output logic [0:`ISU_UNIT_W-1] even_unit_id,
  output logic [0:`ISU_LAT_W-1]  even_latency,
  output logic [0:`ISU_IMM_W-1]  even_imm,
  output logic [0:`ISU_REG_W-1]  even_ra_addr,
  output logic [0:`ISU_REG_W-1]  even_rb_addr,
  output logic [0:`ISU_REG_W-1]  even_rc_addr,
  output logic [0:`ISU_ID_W-1]   odd_instr_id,
  output logic [0:`ISU_REG_W-1]  odd_reg_dst,
  output logic                   odd_reg_wr,
  output logic [0:`ISU_UNIT_W-1] odd_unit_id,
  output logic [0:`ISU_LAT_W-1]  odd_latency,
  output logic [0:`ISU_IMM_W-1]  odd_imm,
  output logic [0:`ISU_REG_W-1]  odd_ra_addr,
  output logic [0:`ISU_REG_W-1]  odd_rb_addr,
  output logic [0:`ISU_REG_W-1]  odd_rc_addr
);

  localparam int slot_w = `ISU_ID_W + 4 * `ISU_REG_W + 1 + `ISU_UNIT_W + `ISU_LAT_W +
                          `ISU_IMM_W;

  logic              pending; // instr2 of a split pair still to go
  logic              send1;
  logic              send2;
  logic [0:slot_w-1] slot1, slot2;
  logic [0:slot_w-1] fill_even, fill_odd;
  logic [0:slot_w-1] even_d, odd_d;
  logic [0:slot_w-1] even_q, odd_q;

  assign slot1 = {id1, reg_dst1, reg_wr1, unit_id1, latency1, imm1, ra_addr1, rb_addr1, rc_addr1};
  assign slot2 = {id2, reg_dst2, reg_wr2, unit_id2, latency2, imm2, ra_addr2, rb_addr2, rc_addr2};

  assign fill_even = {filler_id(1'b1), {(slot_w-`ISU_ID_W){1'b0}}};
  assign fill_odd  = {filler_id(1'b0), {(slot_w-`ISU_ID_W){1'b0}}};

  assign stall = split_needed & ~pending;

  always_comb begin
    send1 = 1'b1;
    send2 = 1'b1;
    if (pending) begin
      send1 = 1'b0; // instr1 already went out last cycle
    end else if (split_needed) begin
      send2 = 1'b0;
    end else if (find_nop) begin
      send1 = 1'b0;
    end
  end

  assign even_d = (send1 && instr1_even)  ? slot1 :
                  (send2 && instr2_even)  ? slot2 : fill_even;
  assign odd_d  = (send1 && !instr1_even) ? slot1 :
                  (send2 && !instr2_even) ? slot2 : fill_odd;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pending <= 1'b0;
      even_q  <= fill_even;
      odd_q   <= fill_odd;
    end else begin
      pending <= stall; // set on the first half, cleared on the second
      even_q  <= even_d;
      odd_q   <= odd_d;
    end
  end

  assign {even_instr_id, even_reg_dst, even_reg_wr, even_unit_id, even_latency, even_imm,
          even_ra_addr, even_rb_addr, even_rc_addr} = even_q;
  assign {odd_instr_id, odd_reg_dst, odd_reg_wr, odd_unit_id, odd_latency, odd_imm,
          odd_ra_addr, odd_rb_addr, odd_rc_addr} = odd_q;

endmodule

`default_nettype wire

// ==== src/decode_issue_top.sv ====
`default_nettype none
`include "issue_defs.svh"

module decode_issue_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [0:`ISU_WORD_W-1] instr1,
  input  logic [0:`ISU_WORD_W-1] instr2,
  input  logic                   find_nop,
  output logic                   stall,
  output logic [0:`ISU_ID_W-1]   even_instr_id,
  output logic [0:`ISU_REG_W-1]  even_reg_dst,
  output logic                   even_reg_wr,
  output logic [0:`ISU_UNIT_W-1] even_unit_id,
  output logic [0:`ISU_LAT_W-1]  even_latency,
  output logic [0:`ISU_IMM_W-1]  even_imm,
  output logic [0:`ISU_REG_W-1]  even_ra_addr,
  output logic [0:`ISU_REG_W-1]  even_rb_addr,
  output logic [0:`ISU_REG_W-1]  even_rc_addr,
  output logic [0:`ISU_ID_W-1]   odd_instr_id,
  output logic [0:`ISU_REG_W-1]  odd_reg_dst,
  output logic                   odd_reg_wr,
  output logic [0:`ISU_UNIT_W-1] odd_unit_id,
  output logic [0:`ISU_LAT_W-1]  odd_latency,
  output logic [0:`ISU_IMM_W-1]  odd_imm,
  output logic [0:`ISU_REG_W-1]  odd_ra_addr,
  output logic [0:`ISU_REG_W-1]  odd_rb_addr,
  output logic [0:`ISU_REG_W-1]  odd_rc_addr
);

  logic [0:`ISU_ID_W-1]   id1, id2;
  logic [0:`ISU_REG_W-1]  reg_dst1, reg_dst2;
  logic                   reg_wr1, reg_wr2;
  logic [0:`ISU_UNIT_W-1] unit_id1, unit_id2;
  logic [0:`ISU_LAT_W-1]  latency1, latency2;
  logic [0:`ISU_IMM_W-1]  imm1, imm2;
  logic [0:`ISU_REG_W-1]  ra_addr1, ra_addr2, rb_addr1, rb_addr2, rc_addr1, rc_addr2;
  logic                   ra_used2, rb_used2, rc_used2;
  logic                   instr1_even, instr2_even, split_needed;

  // source use of instr1 plays no part in pair hazards
  instr_decoder dec1 (
    .word(instr1), .id(id1), .reg_dst(reg_dst1), .reg_wr(reg_wr1), .unit_id(unit_id1),
    .latency(latency1), .imm(imm1), .ra_addr(ra_addr1), .rb_addr(rb_addr1),
    .rc_addr(rc_addr1), .ra_used(), .rb_used(), .rc_used()
  );

  instr_decoder dec2 (
    .word(instr2), .id(id2), .reg_dst(reg_dst2), .reg_wr(reg_wr2), .unit_id(unit_id2),
    .latency(latency2), .imm(imm2), .ra_addr(ra_addr2), .rb_addr(rb_addr2),
    .rc_addr(rc_addr2), .ra_used(ra_used2), .rb_used(rb_used2), .rc_used(rc_used2)
  );

  pair_hazard_check hazard (.*);

  dual_issue_ctrl issue (.*);

endmodule

`default_nettype wire

// ==== verification/tb_decode_issue.sv ====
`default_nettype none
`include "issue_defs.svh"

module tb_decode_issue
  import isa_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int sw = `ISU_ID_W + 4 * `ISU_REG_W + 1 + `ISU_UNIT_W + `ISU_LAT_W + `ISU_IMM_W;
  localparam logic [0:sw-1] fill_even = {`ISU_ID_NOP, {(sw-`ISU_ID_W){1'b0}}};
  localparam logic [0:sw-1] fill_odd  = {`ISU_ID_LNOP, {(sw-`ISU_ID_W){1'b0}}};

  logic clk, rst, find_nop, stall;
  logic [0:`ISU_WORD_W-1] instr1, instr2;
  logic [0:`ISU_ID_W-1] even_instr_id, odd_instr_id;
  logic [0:`ISU_REG_W-1] even_reg_dst, even_ra_addr, even_rb_addr, even_rc_addr;
  logic [0:`ISU_REG_W-1] odd_reg_dst, odd_ra_addr, odd_rb_addr, odd_rc_addr;
  logic even_reg_wr, odd_reg_wr;
  logic [0:`ISU_UNIT_W-1] even_unit_id, odd_unit_id;
  logic [0:`ISU_LAT_W-1] even_latency, odd_latency;
  logic [0:`ISU_IMM_W-1] even_imm, odd_imm;
  logic [0:sw-1] even_act, odd_act;

  // stimulus table with the expected slots of each row
  logic [0:`ISU_WORD_W-1] w1_t[$], w2_t[$];
  logic fn_t[$], st_t[$];
  string name_t[$];
  logic [0:sw-1] e1_t[$], o1_t[$], e2_t[$], o2_t[$];
  int errors = 0;
  bit table_ready = 0;

  decode_issue_top dut (.*);

  assign even_act = {even_instr_id, even_reg_dst, even_reg_wr, even_unit_id, even_latency,
                     even_imm, even_ra_addr, even_rb_addr, even_rc_addr};
  assign odd_act = {odd_instr_id, odd_reg_dst, odd_reg_wr, odd_unit_id, odd_latency,
                    odd_imm, odd_ra_addr, odd_rb_addr, odd_rc_addr};

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [0:31] enc_rr(logic [0:10] op, logic [0:6] rb, ra, rt);
    instr_word_u u;
    u.rr = '{op, rb, ra, rt};
    return u;
  endfunction

  function automatic logic [0:31] enc_ri10(logic [0:7] op, logic [0:9] i10, logic [0:6] ra, rt);
    instr_word_u u;
    u.ri10 = '{op, i10, ra, rt};
    return u;
  endfunction

  function automatic logic [0:31] enc_ri16(logic [0:15] i16, logic [0:6] rt);
    instr_word_u u;
    u.ri16 = '{`ISU_OP_IL, i16, rt};
    return u;
  endfunction

  function automatic logic [0:31] enc_ri18(logic [0:17] i18, logic [0:6] rt);
    instr_word_u u;
    u.ri18 = '{`ISU_OP_ILA, i18, rt};
    return u;
  endfunction

  // reference decode straight from the instruction formats
  function automatic void model_decode(input logic [0:31] word, output logic [0:sw-1] slot,
                                       output logic even, output logic wr,
                                       output logic [0:6] dst, ra, rb, rc,
                                       output logic [0:2] used);
    instr_word_u u;
    logic [0:`ISU_ID_W-1] id;
    logic [0:`ISU_IMM_W-1] imm;
    u = word;
    {id, wr, dst, ra, rb, rc, used, imm} = '0;
    even = 1'b1;
    if (u.rr.op == `ISU_OP_A) begin
      {id, wr, dst, ra, rb, used} = {`ISU_ID_A, 1'b1, u.rr.rt, u.rr.ra, u.rr.rb, 3'b110};
    end else if (u.rr.op == `ISU_OP_LNOP) begin
      id = `ISU_ID_LNOP;
      even = 1'b0;
    end else if (u.rr.op != `ISU_OP_NOP && u.ri16.op == `ISU_OP_IL) begin
      {id, wr, dst, imm} = {`ISU_ID_IL, 1'b1, u.ri16.rt, 2'b00, u.ri16.i16};
    end else if (u.rr.op != `ISU_OP_NOP && u.ri10.op == `ISU_OP_AI) begin
      {id, wr, dst, ra, used} = {`ISU_ID_AI, 1'b1, u.ri10.rt, u.ri10.ra, 3'b100};
      imm = {8'd0, u.ri10.i10};
    end else if (u.rr.op != `ISU_OP_NOP && u.ri10.op == `ISU_OP_LQD) begin
      {id, wr, dst, ra, used} = {`ISU_ID_LQD, 1'b1, u.ri10.rt, u.ri10.ra, 3'b100};
      imm = {8'd0, u.ri10.i10};
      even = 1'b0;
    end else if (u.rr.op != `ISU_OP_NOP && u.ri10.op == `ISU_OP_STQD) begin
      {id, ra, rc, used} = {`ISU_ID_STQD, u.ri10.ra, u.ri10.rt, 3'b101}; // store reads rt
      imm = {8'd0, u.ri10.i10};
      even = 1'b0;
    end else if (u.rr.op != `ISU_OP_NOP && u.ri18.op == `ISU_OP_ILA) begin
      {id, wr, dst, imm} = {`ISU_ID_ILA, 1'b1, u.ri18.rt, u.ri18.i18};
    end
    if (id == `ISU_ID_NOP || id == `ISU_ID_LNOP) begin
      slot = {id, {(sw-`ISU_ID_W){1'b0}}};
    end else if (even) begin
      slot = {id, dst, wr, `ISU_UNIT_FX, `ISU_LAT_FX, imm, ra, rb, rc};
    end else begin
      slot = {id, dst, wr, `ISU_UNIT_LS, `ISU_LAT_LS, imm, ra, rb, rc};
    end
  endfunction

  task automatic add_row(string name, logic [0:31] w1, w2, logic fn, logic st, bit use_model);
    logic [0:sw-1] s1, s2;
    logic ev1, ev2, wr1, wr2, split;
    logic [0:6] d1, a1, b1, c1, d2, a2, b2, c2;
    logic [0:2] u1, u2;
    model_decode(w1, s1, ev1, wr1, d1, a1, b1, c1, u1);
    model_decode(w2, s2, ev2, wr2, d2, a2, b2, c2, u2);
    split = (ev1 == ev2) ||
            (wr1 && ((u2[0] && a2 == d1) || (u2[1] && b2 == d1) || (u2[2] && c2 == d1)));
    w1_t.push_back(w1);
    w2_t.push_back(w2);
    fn_t.push_back(fn);
    name_t.push_back(name);
    st_t.push_back(use_model ? split : st);
    if (split) begin
      e1_t.push_back(ev1 ? s1 : fill_even);
      o1_t.push_back(ev1 ? fill_odd : s1);
      e2_t.push_back(ev2 ? s2 : fill_even);
      o2_t.push_back(ev2 ? fill_odd : s2);
    end else begin
      e1_t.push_back(fn ? (ev2 ? s2 : fill_even) : (ev1 ? s1 : s2));
      o1_t.push_back(fn ? (ev2 ? fill_odd : s2) : (ev1 ? s2 : s1));
      e2_t.push_back(fill_even);
      o2_t.push_back(fill_odd);
    end
  endtask

  function automatic logic [0:31] random_word();
    logic [0:6] r1, r2, r3;
    r1 = 7'($urandom % 8); // small register range so dependencies occur
    r2 = 7'($urandom % 8);
    r3 = 7'($urandom % 8);
    case ($urandom % 8)
      0: return enc_rr(`ISU_OP_A, r1, r2, r3);
      1: return enc_ri10(`ISU_OP_AI, 10'($urandom), r2, r3);
      2: return enc_ri16(16'($urandom), r3);
      3: return enc_ri18(18'($urandom), r3);
      4: return enc_ri10(`ISU_OP_LQD, 10'($urandom), r2, r3);
      5: return enc_ri10(`ISU_OP_STQD, 10'($urandom), r2, r3);
      6: return enc_rr(`ISU_OP_NOP, 0, 0, 0);
      default: return enc_rr(`ISU_OP_LNOP, 0, 0, 0);
    endcase
  endfunction

  task automatic check_slot(string name, string which, logic [0:sw-1] exp, logic [0:sw-1] act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s slot expected %h actual %h", name, which, exp, act);
    end
  endtask

  task automatic check_stall(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s stall expected %b actual %b", name, exp, act);
    end
  endtask

  initial begin
    logic [0:sw-1] exp_e, exp_o;
    string prev;
    bit have_exp;
    void'($urandom(26194));
    rst = 1'b1;
    find_nop = 1'b0;
    instr1 = enc_rr(`ISU_OP_NOP, 0, 0, 0);
    instr2 = enc_rr(`ISU_OP_LNOP, 0, 0, 0);
    add_row("a_lqd", enc_rr(`ISU_OP_A, 3, 2, 1), enc_ri10(`ISU_OP_LQD, 10'h155, 5, 6), 0, 0, 0);
    add_row("lqd_ai", enc_ri10(`ISU_OP_LQD, 4, 9, 8), enc_ri10(`ISU_OP_AI, 7, 10, 11), 0, 0, 0);
    add_row("il_ila", enc_ri16(16'hbeef, 12), enc_ri18(18'h2abcd, 13), 0, 1, 0);
    add_row("lqd_stqd", enc_ri10(`ISU_OP_LQD, 1, 2, 3), enc_ri10(`ISU_OP_STQD, 5, 6, 7), 0, 1, 0);
    add_row("raw_ila_lqd", enc_ri18(18'h1, 20), enc_ri10(`ISU_OP_LQD, 3, 20, 21), 0, 1, 0);
    add_row("stqd_no_wr", enc_ri10(`ISU_OP_STQD, 2, 31, 30), enc_ri10(`ISU_OP_AI, 1, 30, 32),
            0, 0, 0);
    add_row("ai_rb_unused", enc_ri10(`ISU_OP_LQD, 0, 1, 0), enc_ri10(`ISU_OP_AI, 0, 1, 41),
            0, 0, 0);
    add_row("raw_stqd_rc", enc_ri18(18'h5, 50), enc_ri10(`ISU_OP_STQD, 9, 51, 50), 0, 1, 0);
    add_row("find_nop", enc_rr(`ISU_OP_A, 3, 2, 1), enc_ri10(`ISU_OP_LQD, 8, 5, 6), 1, 0, 0);
    add_row("unknown_op", 32'hffff_ffff, enc_ri10(`ISU_OP_LQD, 8, 5, 6), 0, 0, 0);
    for (int i = 0; i < 24; i++) begin
      add_row($sformatf("random_%0d", i), random_word(), random_word(), ($urandom % 4) == 0,
              0, 1);
    end
    table_ready = 1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_slot("reset", "even", fill_even, even_act);
    check_slot("reset", "odd", fill_odd, odd_act);
    check_stall("reset", 1'b0, stall);
    have_exp = 0;
    for (int i = 0; i < w1_t.size(); i++) begin
      @(posedge clk);
      rst <= 1'b0;
      instr1 <= w1_t[i];
      instr2 <= w2_t[i];
      find_nop <= fn_t[i];
      @(negedge clk);
      if (have_exp) begin
        check_slot(prev, "even", exp_e, even_act);
        check_slot(prev, "odd", exp_o, odd_act);
      end
      check_stall(name_t[i], st_t[i], stall);
      if (st_t[i]) begin
        @(posedge clk); // pair held while stalled
        @(negedge clk);
        check_slot(name_t[i], "even", e1_t[i], even_act);
        check_slot(name_t[i], "odd", o1_t[i], odd_act);
        check_stall(name_t[i], 1'b0, stall);
        {exp_e, exp_o} = {e2_t[i], o2_t[i]};
      end else begin
        {exp_e, exp_o} = {e1_t[i], o1_t[i]};
      end
      prev = name_t[i];
      have_exp = 1;
    end
    @(posedge clk);
    @(negedge clk);
    check_slot(prev, "even", exp_e, even_act);
    check_slot(prev, "odd", exp_o, odd_act);
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (w1_t.size() * 2 + 10) @(posedge clk);
    $display("watchdog expired before the table was applied");
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/instr_decoder.sv
src/pair_hazard_check.sv
src/dual_issue_ctrl.sv
src/decode_issue_top.sv
verification/tb_decode_issue.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode/issue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_decode_issue -o sim_decode_issue

./obj_dir/sim_decode_issue > sim.log 2>&1 || true
cat sim.log

if grep -q "^all tests passed$" sim.log; then
  exit 0
fi
exit 1
